// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module adc_capture_tb -f sources.f -o adc_capture_sim

output=$(./obj_dir/adc_capture_sim) || true
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: sources.f
+incdir+src
src/adc_capture_pkg.sv
src/capture_trigger.sv
src/capture_sequencer.sv
src/buffer_source_mux.sv
src/tx_framer.sv
src/overrange_counters.sv
src/adc_capture_top.sv
verification/qdr_model.sv
verification/adc_capture_tb.sv

// File: src/adc_capture_macros.svh
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

////////////////////////////////////////
// Buffer geometry
////////////////////////////////////////

// Word address into each QDR buffer.
`define QDR_ADDR_W 6

////////////////////////////////////////
// Timing
////////////////////////////////////////

// Backoff lasts 2**BACKOFF_W cycles.
`define BACKOFF_W 4

`define FRAME_WORDS 8 // Transmit words per frame.
`define QDR_RD_LAT 10 // Read strobe to read data.

`endif

// File: src/adc_capture_pkg.sv
`default_nettype none

`include "adc_capture_macros.svh"

package adc_capture_pkg;

  typedef logic [7:0] sample_t;

  // Four samples of one channel, earliest in the upper byte.
  typedef sample_t [3:0] chan_word_t;

  typedef logic [`QDR_ADDR_W-1:0] qdr_addr_t;
  typedef logic [63:0] tx_word_t;
  typedef logic [31:0] event_count_t;

  typedef logic [1:0] chan_sel_t;
  localparam chan_sel_t chan_adc0_i = 2'd0;
  localparam chan_sel_t chan_adc0_q = 2'd1;
  localparam chan_sel_t chan_adc1_i = 2'd2;
  localparam chan_sel_t chan_adc1_q = 2'd3;

  typedef enum logic [1:0] {
    phase_idle  = 2'd0,
    phase_write = 2'd1,
    phase_read  = 2'd2
  } capture_phase_t;

  typedef enum logic [1:0] {
    trig_armed   = 2'd0,
    trig_waiting = 2'd1,
    trig_backoff = 2'd2
  } trigger_state_t;

endpackage

`default_nettype wire

// File: src/adc_capture_top.sv
`default_nettype none

module adc_capture_top import adc_capture_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             start,
  input  wire             manual_mode,
  input  wire chan_sel_t  src0,
  input  wire chan_sel_t  src1,
  input  wire chan_word_t adc0_i,
  input  wire chan_word_t adc0_q,
  input  wire chan_word_t adc1_i,
  input  wire chan_word_t adc1_q,
  input  wire             adc0_ovr_i0,
  input  wire             adc0_ovr_i1,
  input  wire             adc0_ovr_q0,
  input  wire             adc0_ovr_q1,
  input  wire             adc1_ovr_i0,
  input  wire             adc1_ovr_i1,
  input  wire             adc1_ovr_q0,
  input  wire             adc1_ovr_q1,
  input  wire             qdr0_phy_ready,
  input  wire             qdr1_phy_ready,
  output qdr_addr_t       qdr_address,
  output chan_word_t      qdr0_dout,
  output chan_word_t      qdr1_dout,
  output logic            qdr_wr_en,
  output logic            qdr_rd_en,
  input  wire chan_word_t qdr0_din,
  input  wire chan_word_t qdr1_din,
  output tx_word_t        tx_data,
  output logic            tx_valid,
  output logic            tx_end_of_frame,
  output logic            busy,
  output capture_phase_t  phase,
  output event_count_t    count_i0,
  output event_count_t    count_q0,
  output event_count_t    count_i1,
  output event_count_t    count_q1
);

  logic capture_start;
  logic read_done;
  logic frame_last;

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////

  capture_trigger u_trigger (
    .clk, .rst, .start, .manual_mode,
    .qdr0_phy_ready, .qdr1_phy_ready,
    .read_done, .capture_start
  );

  capture_sequencer u_sequencer (
    .clk, .rst, .capture_start,
    .phase, .busy, .qdr_address,
    .qdr_wr_en, .qdr_rd_en,
    .read_done, .frame_last
  );

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  buffer_source_mux u_mux (
    .clk, .adc0_i, .adc0_q, .adc1_i, .adc1_q,
    .manual_mode, .src0, .src1,
    .qdr0_dout, .qdr1_dout
  );

  tx_framer u_framer (
    .clk, .rst,
    .rd_strobe (qdr_rd_en), // Shared read strobe of both buffers.
    .frame_last,
    .qdr0_din, .qdr1_din,
    .tx_data, .tx_valid, .tx_end_of_frame
  );

  overrange_counters u_ovr (
    .clk, .rst,
    .adc0_ovr_i0, .adc0_ovr_i1, .adc0_ovr_q0, .adc0_ovr_q1,
    .adc1_ovr_i0, .adc1_ovr_i1, .adc1_ovr_q0, .adc1_ovr_q1,
    .count_i0, .count_q0, .count_i1, .count_q1
  );

endmodule

`default_nettype wire

// File: src/buffer_source_mux.sv
`default_nettype none

module buffer_source_mux import adc_capture_pkg::*; (
  input  wire             clk,
  input  wire chan_word_t adc0_i,
  input  wire chan_word_t adc0_q,
  input  wire chan_word_t adc1_i,
  input  wire chan_word_t adc1_q,
  input  wire             manual_mode,
  input  wire chan_sel_t  src0,
  input  wire chan_sel_t  src1,
  output chan_word_t      qdr0_dout,
  output chan_word_t      qdr1_dout
);

  chan_sel_t sel0;
  chan_sel_t sel1;

  function automatic chan_word_t pick(input chan_sel_t sel);
    chan_word_t w;
    case (sel)
      chan_adc0_i: w = adc0_i;
      chan_adc0_q: w = adc0_q;
      chan_adc1_i: w = adc1_i;
      default:     w = adc1_q;
    endcase
    return w;
  endfunction

  // Default routing is ADC0 I and Q.
  assign sel0 = manual_mode ? src0 : chan_adc0_i;
  assign sel1 = manual_mode ? src1 : chan_adc0_q;

  always_ff @(posedge clk) begin
    qdr0_dout <= pick(sel0);
    qdr1_dout <= pick(sel1);
  end

endmodule

`default_nettype wire

// File: src/capture_sequencer.sv
`default_nettype none

`include "adc_capture_macros.svh"

module capture_sequencer import adc_capture_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            capture_start,
  output capture_phase_t phase,
  output logic           busy,
  output qdr_addr_t      qdr_address,
  output logic           qdr_wr_en,
  output logic           qdr_rd_en,
  output logic           read_done,
  output logic           frame_last
);

  localparam int FRAME_W = $clog2(`FRAME_WORDS);
  localparam qdr_addr_t addr_max = '1;

  qdr_addr_t progress;
  logic step;        // High on strobe slots.
  logic last_strobe; // Final strobe of the phase issued.

  assign busy = (phase != phase_idle);

  ////////////////////////////////////////
  // Phase machine and strobes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    qdr_wr_en  <= 1'b0;
    qdr_rd_en  <= 1'b0;
    read_done  <= 1'b0;
    frame_last <= 1'b0;
    if (rst) begin
      phase       <= phase_idle;
      progress    <= '0;
      step        <= 1'b0;
      last_strobe <= 1'b0;
      qdr_address <= '0;
    end else begin
      case (phase)
        phase_idle: begin
          progress    <= '0;
          step        <= 1'b0;
          last_strobe <= 1'b0;
          if (capture_start) phase <= phase_write;
        end
        phase_write: begin
          step <= ~step;
          if (step) begin
            qdr_wr_en   <= 1'b1;
            qdr_address <= progress;
            progress    <= progress + 1'b1; // Wraps to zero for the read pass.
            last_strobe <= (progress == addr_max);
          end else if (last_strobe) begin
            phase       <= phase_read;
            step        <= 1'b0;
            last_strobe <= 1'b0;
          end
        end
        phase_read: begin
          step <= ~step;
          if (step) begin
            qdr_rd_en   <= 1'b1;
            qdr_address <= progress;
            progress    <= progress + 1'b1;
            last_strobe <= (progress == addr_max);
            frame_last  <= (progress[FRAME_W-1:0] == FRAME_W'(`FRAME_WORDS - 1));
          end else if (last_strobe) begin
            phase       <= phase_idle;
            read_done   <= 1'b1;
            last_strobe <= 1'b0;
          end
        end
        default: phase <= phase_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
    !(qdr_wr_en && qdr_rd_en));

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    (phase == phase_idle) |-> !(qdr_wr_en || qdr_rd_en));

endmodule

`default_nettype wire

// File: src/capture_trigger.sv
`default_nettype none

`include "adc_capture_macros.svh"

module capture_trigger import adc_capture_pkg::*; (
  input  wire  clk,
  input  wire  rst,
  input  wire  start,
  input  wire  manual_mode,
  input  wire  qdr0_phy_ready,
  input  wire  qdr1_phy_ready,
  input  wire  read_done,
  output logic capture_start
);

  trigger_state_t state;
  logic start_q;
  logic start_qq;
  logic start_edge;
  logic phy_ready;
  logic [`BACKOFF_W-1:0] backoff_cnt;

  assign start_edge = start_q & ~start_qq;
  assign phy_ready  = qdr0_phy_ready & qdr1_phy_ready;

  // Input register, then edge detect.
  always_ff @(posedge clk) begin
    if (rst) begin
      start_q  <= 1'b0;
      start_qq <= 1'b0;
    end else begin
      start_q  <= start;
      start_qq <= start_q;
    end
  end

  always_ff @(posedge clk) begin
    capture_start <= 1'b0;
    if (rst || !phy_ready) begin
      state       <= trig_backoff; // Hold off until both PHYs are up.
      backoff_cnt <= '0;
    end else begin
      case (state)
        trig_armed: begin
          if (!manual_mode || start_edge) begin
            capture_start <= 1'b1;
            state         <= trig_waiting;
          end
        end
        trig_waiting: begin
          if (read_done) begin
            state       <= trig_backoff;
            backoff_cnt <= '0;
          end
        end
        trig_backoff: begin
          backoff_cnt <= backoff_cnt + 1'b1;
          if (&backoff_cnt) state <= trig_armed;
        end
        default: state <= trig_backoff;
      endcase
    end
  end

  // One capture per arming.
  a_single_start: assert property (@(posedge clk) disable iff (rst)
    capture_start |=> !capture_start);

endmodule

`default_nettype wire

// File: src/overrange_counters.sv
`default_nettype none

module overrange_counters import adc_capture_pkg::*; (
  input  wire   clk,
  input  wire   rst,
  input  wire   adc0_ovr_i0,
  input  wire   adc0_ovr_i1,
  input  wire   adc0_ovr_q0,
  input  wire   adc0_ovr_q1,
  input  wire   adc1_ovr_i0,
  input  wire   adc1_ovr_i1,
  input  wire   adc1_ovr_q0,
  input  wire   adc1_ovr_q1,
  output event_count_t count_i0,
  output event_count_t count_q0,
  output event_count_t count_i1,
  output event_count_t count_q1
);

  logic [3:0]   hit;
  event_count_t cnt [4];

  // Either flag of a channel counts once.
  assign hit[0] = adc0_ovr_i0 | adc0_ovr_i1;
  assign hit[1] = adc0_ovr_q0 | adc0_ovr_q1;
  assign hit[2] = adc1_ovr_i0 | adc1_ovr_i1;
  assign hit[3] = adc1_ovr_q0 | adc1_ovr_q1;

  for (genvar k = 0; k < 4; k++) begin : g_cnt
    always_ff @(posedge clk) begin
      if (rst) begin
        cnt[k] <= '0;
      end else if (hit[k]) begin
        cnt[k] <= cnt[k] + 1'b1;
      end
    end
  end

  assign count_i0 = cnt[0];
  assign count_q0 = cnt[1];
  assign count_i1 = cnt[2];
  assign count_q1 = cnt[3];

endmodule

`default_nettype wire

// File: src/tx_framer.sv
`default_nettype none

`include "adc_capture_macros.svh"

module tx_framer import adc_capture_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             rd_strobe,
  input  wire             frame_last,
  input  wire chan_word_t qdr0_din,
  input  wire chan_word_t qdr1_din,
  output tx_word_t        tx_data,
  output logic            tx_valid,
  output logic            tx_end_of_frame
);

  // Read latency plus one for the input register.
  logic [`QDR_RD_LAT:0] valid_dly;
  logic [`QDR_RD_LAT:0] eof_dly;
  logic                 data_due;

  assign data_due = valid_dly[`QDR_RD_LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_dly <= '0;
      eof_dly   <= '0;
    end else begin
      valid_dly <= {valid_dly[`QDR_RD_LAT-1:0], rd_strobe};
      eof_dly   <= {eof_dly[`QDR_RD_LAT-1:0], frame_last};
    end
  end

  ////////////////////////////////////////
  // Output word
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_valid        <= 1'b0;
      tx_end_of_frame <= 1'b0;
    end else begin
      tx_valid        <= data_due;
      tx_end_of_frame <= eof_dly[`QDR_RD_LAT];
    end
  end

  always_ff @(posedge clk) begin
    if (data_due) tx_data <= {qdr0_din, qdr1_din}; // Buffer 0 in upper half.
  end

  a_eof_valid: assert property (@(posedge clk) disable iff (rst)
    tx_end_of_frame |-> tx_valid);

endmodule

`default_nettype wire

// File: verification/adc_capture_tb.sv
`default_nettype none

`include "adc_capture_macros.svh"

module adc_capture_tb import adc_capture_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth          = 1 << `QDR_ADDR_W;
  localparam int backoff        = 1 << `BACKOFF_W;
  localparam int capture_cycles = 4 * depth + `QDR_RD_LAT + 8;
  localparam int run_cycles     = 16 + 4 * (capture_cycles + backoff) + 200;

  logic           clk, rst, start, manual_mode;
  logic           qdr0_phy_ready, qdr1_phy_ready;
  chan_sel_t      src0, src1;
  chan_word_t     adc0_i, adc0_q, adc1_i, adc1_q;
  logic           adc0_ovr_i0, adc0_ovr_i1, adc0_ovr_q0, adc0_ovr_q1;
  logic           adc1_ovr_i0, adc1_ovr_i1, adc1_ovr_q0, adc1_ovr_q1;
  qdr_addr_t      qdr_address;
  chan_word_t     qdr0_dout, qdr1_dout, qdr0_din, qdr1_din;
  logic           qdr_wr_en, qdr_rd_en, tx_valid, tx_end_of_frame, busy;
  tx_word_t       tx_data;
  capture_phase_t phase;
  event_count_t   count_i0, count_q0, count_i1, count_q1;

  string        test_name;
  int           errors, order_errors0, order_errors1;
  int           cycle, captures, writes, reads, tx_words, frame_ends;
  logic         busy_prev, prev_manual;
  chan_sel_t    prev_src0, prev_src1;
  chan_word_t   adc_prev [4];
  chan_word_t   cap0 [depth];
  chan_word_t   cap1 [depth];
  event_count_t tally [4];
  int           rd_cycle_q [$];
  qdr_addr_t    rd_addr_q [$];

  adc_capture_top dut0 (.*);

  qdr_model qdr0 (
    .clk, .rst, .address(qdr_address), .wr_en(qdr_wr_en), .rd_en(qdr_rd_en),
    .din(qdr0_dout), .dout(qdr0_din), .order_errors(order_errors0)
  );

  qdr_model qdr1 (
    .clk, .rst, .address(qdr_address), .wr_en(qdr_wr_en), .rd_en(qdr_rd_en),
    .din(qdr1_dout), .dout(qdr1_din), .order_errors(order_errors1)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    errors++;
  endtask

  // Channel that the mux should have routed from last cycle's inputs.
  function automatic chan_word_t routed_word(input logic manual, input chan_sel_t src,
                                             input chan_sel_t dflt);
    chan_sel_t sel;
    sel = manual ? src : dflt;
    return adc_prev[sel];
  endfunction

  function automatic tx_word_t expected_word(input qdr_addr_t a);
    return {cap0[a], cap1[a]};
  endfunction

  function automatic logic expected_last(input qdr_addr_t a);
    return ((int'(a) + 1) % `FRAME_WORDS) == 0;
  endfunction

  always @(negedge clk) begin
    chan_word_t exp0;
    chan_word_t exp1;
    qdr_addr_t  rd_addr;
    int         rd_cycle;
    cycle++;
    if (rst) begin
      tally = '{default: '0};
    end else begin
      check_value("count_i0", 64'(tally[0]), 64'(count_i0));
      check_value("count_q0", 64'(tally[1]), 64'(count_q0));
      check_value("count_i1", 64'(tally[2]), 64'(count_i1));
      check_value("count_q1", 64'(tally[3]), 64'(count_q1));
      if (adc0_ovr_i0 || adc0_ovr_i1) tally[0]++;
      if (adc0_ovr_q0 || adc0_ovr_q1) tally[1]++;
      if (adc1_ovr_i0 || adc1_ovr_i1) tally[2]++;
      if (adc1_ovr_q0 || adc1_ovr_q1) tally[3]++;
      if (busy && !busy_prev) captures++;
      if (qdr_wr_en) begin
        exp0 = routed_word(prev_manual, prev_src0, chan_adc0_i);
        exp1 = routed_word(prev_manual, prev_src1, chan_adc0_q);
        check_value("write phase", 64'(phase_write), 64'(phase));
        check_value("write address", 64'(qdr_addr_t'(writes)), 64'(qdr_address));
        check_value("buffer 0 word", 64'(exp0), 64'(qdr0_dout));
        check_value("buffer 1 word", 64'(exp1), 64'(qdr1_dout));
        cap0[qdr_address] = exp0;
        cap1[qdr_address] = exp1;
        writes++;
      end
      if (qdr_rd_en) begin
        check_value("read phase", 64'(phase_read), 64'(phase));
        check_value("read address", 64'(qdr_addr_t'(reads)), 64'(qdr_address));
        rd_cycle_q.push_back(cycle);
        rd_addr_q.push_back(qdr_address);
        reads++;
      end
      if (tx_valid) begin
        assert (rd_addr_q.size() > 0) else report_error("transmit word with no read strobe");
        if (rd_addr_q.size() > 0) begin
          rd_addr  = rd_addr_q.pop_front();
          rd_cycle = rd_cycle_q.pop_front();
          check_value("read to valid", 64'(`QDR_RD_LAT + 2), 64'(cycle - rd_cycle));
          check_value("tx_data", expected_word(rd_addr), tx_data);
          check_value("tx_end_of_frame", 64'(expected_last(rd_addr)), 64'(tx_end_of_frame));
        end
        tx_words++;
        if (tx_end_of_frame) frame_ends++;
      end else if (tx_end_of_frame) begin
        report_error("tx_end_of_frame high without tx_valid");
      end
    end
    busy_prev   = busy;
    prev_manual = manual_mode;
    prev_src0   = src0;
    prev_src1   = src1;
    adc_prev    = '{adc0_i, adc0_q, adc1_i, adc1_q};
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h894b_15f1));
    {adc0_i, adc0_q, adc1_i, adc1_q} = '0;
    {adc0_ovr_i0, adc0_ovr_i1, adc0_ovr_q0, adc0_ovr_q1} = '0;
    {adc1_ovr_i0, adc1_ovr_i1, adc1_ovr_q0, adc1_ovr_q1} = '0;
    forever begin
      @(posedge clk);
      #2;
      adc0_i = $urandom;
      adc0_q = $urandom;
      adc1_i = $urandom;
      adc1_q = $urandom;
      {adc0_ovr_i0, adc0_ovr_i1, adc0_ovr_q0, adc0_ovr_q1,
       adc1_ovr_i0, adc1_ovr_i1, adc1_ovr_q0, adc1_ovr_q1} = 8'($urandom);
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic await_capture(input int n);
    wait (captures == n && !busy && tx_words == n * depth);
    check_value("write count", 64'(n * depth), 64'(writes));
    check_value("read count", 64'(n * depth), 64'(reads));
    check_value("frame count", 64'(n * depth / `FRAME_WORDS), 64'(frame_ends));
    @(posedge clk);
    #2;
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    start          = 1'b0;
    manual_mode    = 1'b1;
    src0           = chan_adc0_i;
    src1           = chan_adc0_q;
    qdr0_phy_ready = 1'b1;
    qdr1_phy_ready = 1'b1;
    test_name      = "reset";
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_value("strobes, busy, phase", 64'({4'b0, phase_idle}),
                64'({tx_valid, qdr_wr_en, qdr_rd_en, busy, phase}));
    check_value("counts 0", '0, {count_i0, count_q0});
    check_value("counts 1", '0, {count_i1, count_q1});
    @(posedge clk);
    #2;
    rst = 1'b0;

    test_name = "manual_default";
    idle_cycles(backoff + 4);
    start = 1'b1;
    idle_cycles(4);
    start = 1'b0;
    await_capture(1);

    test_name = "manual_routing";
    src0 = chan_adc1_q;
    src1 = chan_adc1_i;
    idle_cycles(backoff + 4);
    start = 1'b1; // Held high past the capture.
    await_capture(2);
    idle_cycles(2 * backoff + 8);
    assert (captures == 2 && !busy) else report_error("start held high began another capture");
    start = 1'b0;

    test_name = "free_running";
    src0           = chan_adc1_i; // Ignored until manual mode returns.
    src1           = chan_adc1_q;
    manual_mode    = 1'b0;
    qdr0_phy_ready = 1'b0;
    idle_cycles(3 * backoff);
    assert (captures == 2 && !busy && writes + reads == 4 * depth)
      else report_error("capture activity while the qdr0 PHY was not ready");
    qdr0_phy_ready = 1'b1;
    await_capture(3);
    wait (captures == 4);
    @(posedge clk);
    #2;
    manual_mode = 1'b1; // No restart after this capture.
    await_capture(4);
    idle_cycles(2 * backoff + 8);
    assert (captures == 4) else report_error("captures went on after manual mode was set");

    $display("Errors: %0d checks, %0d buffer 0 order, %0d buffer 1 order",
             errors, order_errors0, order_errors1);
    if (errors == 0 && order_errors0 == 0 && order_errors1 == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(2 * run_cycles * 40);
    $display("Watchdog expired after %0d cycles before the tests ended", 2 * run_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/qdr_model.sv
`default_nettype none

`include "adc_capture_macros.svh"

module qdr_model import adc_capture_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire qdr_addr_t  address,
  input  wire             wr_en,
  input  wire             rd_en,
  input  wire chan_word_t din,
  output chan_word_t      dout,
  output int              order_errors
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth = 1 << `QDR_ADDR_W;

  chan_word_t                      mem [depth];
  logic [`QDR_RD_LAT-2:0]          rd_pipe;
  qdr_addr_t [`QDR_RD_LAT-2:0]     addr_pipe;
  qdr_addr_t                       next_wr;

  // Data appears QDR_RD_LAT cycles after the strobe and holds until the next read.
  always @(posedge clk) begin
    addr_pipe <= {addr_pipe[`QDR_RD_LAT-3:0], address};
    if (rst) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[`QDR_RD_LAT-3:0], rd_en};
      if (rd_pipe[`QDR_RD_LAT-2]) dout <= mem[addr_pipe[`QDR_RD_LAT-2]];
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      next_wr      <= '0;
      order_errors <= 0;
    end else if (wr_en) begin
      mem[address] <= din;
      next_wr      <= address + 1'b1; // Wraps for the next capture.
      assert (address == next_wr) else begin
        $display("ERROR %m: write to address %0d while address %0d was due", address, next_wr);
        order_errors <= order_errors + 1;
      end
    end
  end

endmodule

`default_nettype wire
